// ==== Bender.yml ====
package:
  name: dma_wr_mgr

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/axi_pkg.sv
      - hw/dma_pkg.sv
      - hw/dma_req_queue.sv
      - hw/axi_aw_issue.sv
      - hw/axi_w_stream.sv
      - hw/dma_wr_complete.sv
      - hw/dma_wr_mgr.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/tb_dma_wr_mgr.sv

// ==== compile.f ====
+incdir+hw
hw/axi_pkg.sv
hw/dma_pkg.sv
hw/dma_req_queue.sv
hw/axi_aw_issue.sv
hw/axi_w_stream.sv
hw/dma_wr_complete.sv
hw/dma_wr_mgr.sv
sim/tb_dma_wr_mgr.sv

// ==== hw/axi_aw_issue.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module axi_aw_issue import axi_pkg::*, dma_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    // Queue read side
    input  logic                 i_avail,
    input  logic [`DMA_AW-1:0]   i_addr,
    input  logic [`DMA_LENW-1:0] i_len,
    input  dma_op_e              i_op,
    output logic                 o_pop,

    // AW channel
    output logic                 o_awvalid,
    input  logic                 i_awready,
    output logic [`DMA_AW-1:0]   o_awaddr,
    output logic [`DMA_LENW-1:0] o_awlen,
    output logic [2:0]           o_awsize,
    output axi_burst_e           o_awburst,
    output logic                 o_awlock,
    output logic                 o_awid,

    // To completion unit
    output logic                 o_aw_done
);

    logic aw_hs;

    // Head entry stays put until the handshake, so fields are stable
    always_comb o_awvalid = i_avail;
    always_comb aw_hs     = o_awvalid && i_awready;

    always_comb begin
        o_awaddr  = i_addr;
        o_awlen   = i_len;
        o_awsize  = 3'($clog2(`DMA_BC));
        o_awid    = 1'b0;
        o_awburst = INCR;
        o_awlock  = 1'b0;
        case (i_op)
            WR_FIXED:     o_awburst = FIXED;
            WR_INCR_LOCK: o_awlock  = 1'b1;
            default:      o_awburst = INCR;
        endcase
    end

    // One pop and one done pulse per accepted address
    always_comb o_pop     = aw_hs;
    always_comb o_aw_done = aw_hs;

endmodule

// ==== hw/axi_pkg.sv ====
package axi_pkg;

    // AWBURST / ARBURST encoding
    // WRAP left out, no wrapping bursts issued
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01
    } axi_burst_e;

    // BRESP / RRESP encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

// ==== hw/axi_w_stream.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module axi_w_stream import dma_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    // Queue read side
    input  logic                 i_avail,
    input  logic [`DMA_LENW-1:0] i_len,
    output logic                 o_pop,

    // Data FIFO
    input  logic                 i_data_valid,
    input  logic [`DMA_DW-1:0]   i_data,
    output logic                 o_data_ready,

    // W channel
    output logic                 o_wvalid,
    input  logic                 i_wready,
    output logic [`DMA_DW-1:0]   o_wdata,
    output logic [`DMA_BC-1:0]   o_wstrb,
    output logic                 o_wlast,

    // To completion unit
    output logic                 o_w_done
);

    w_state_e             state;
    logic [`DMA_LENW-1:0] beat_cnt;
    // Counter value seen this cycle, straight from the queue when idle
    logic [`DMA_LENW-1:0] cnt_cur;
    logic                 active;
    logic                 w_hs;

    // Idle with an entry waiting streams at once, no bubble between bursts
    always_comb active  = (state == BURST) || i_avail;
    always_comb cnt_cur = (state == BURST) ? beat_cnt : i_len;

    always_comb begin
        o_wvalid     = active && i_data_valid;
        o_data_ready = active && i_wready;
        o_wdata      = i_data;
        o_wstrb      = '1;
        o_wlast      = (cnt_cur == '0);
    end

    always_comb w_hs     = o_wvalid && i_wready;
    always_comb o_pop    = w_hs && o_wlast;
    always_comb o_w_done = w_hs && o_wlast;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end
        else if (w_hs) begin
            if (o_wlast) begin
                // Burst finished, next entry picked up from idle
                state <= IDLE;
            end
            else begin
                state    <= BURST;
                beat_cnt <= cnt_cur - 1'b1;
            end
        end
        else if (state == IDLE && i_avail) begin
            // Load length while waiting on FIFO or wready
            state    <= BURST;
            beat_cnt <= i_len;
        end
    end

endmodule

// ==== hw/dma_consts.svh ====
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// AXI address width
`define DMA_AW 32

// Write data width
`define DMA_DW 32

// Bytes per data beat
`define DMA_BC 4

// Command queue entries, also the credits owned by the requester after reset
`define DMA_QDEPTH 4

// Requester tag width
`define DMA_TAGW 4

// AXI len field width
`define DMA_LENW 8

`endif

// ==== hw/dma_pkg.sv ====
package dma_pkg;

    // Command opcode from the requester
    typedef enum logic [1:0] {
        // Incrementing burst
        WR_INCR      = 2'b00,
        // Same address every beat
        WR_FIXED     = 2'b01,
        // Incrementing, exclusive access
        WR_INCR_LOCK = 2'b10
    } dma_op_e;

    // Result reported with each completion
    typedef enum logic [1:0] {
        DONE_OK      = 2'b00,
        DONE_SLV_ERR = 2'b01,
        DONE_DEC_ERR = 2'b10
    } dma_status_e;

    // W channel streamer state
    typedef enum logic {
        IDLE  = 1'b0,
        BURST = 1'b1
    } w_state_e;

endpackage

// ==== hw/dma_req_queue.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module dma_req_queue import dma_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 i_req_valid,
    input  logic [`DMA_AW-1:0]   i_req_addr,
    input  logic [`DMA_LENW-1:0] i_req_len,
    input  dma_op_e              i_req_op,
    input  logic [`DMA_TAGW-1:0] i_req_tag,
    output logic                 o_req_credit,

    input  logic                 i_aw_pop,
    output logic                 o_aw_avail,
    output logic [`DMA_AW-1:0]   o_aw_addr,
    output logic [`DMA_LENW-1:0] o_aw_len,
    output dma_op_e              o_aw_op,

    input  logic                 i_w_pop,
    output logic                 o_w_avail,
    output logic [`DMA_LENW-1:0] o_w_len,

    input  logic                 i_cmp_pop,
    output logic [`DMA_TAGW-1:0] o_cmp_tag,
    output logic [`DMA_LENW-1:0] o_cmp_len
);

    localparam int PW = $clog2(`DMA_QDEPTH);

    // Entry storage
    logic [`DMA_AW-1:0]   addr_mem [`DMA_QDEPTH];
    logic [`DMA_LENW-1:0] len_mem  [`DMA_QDEPTH];
    dma_op_e              op_mem   [`DMA_QDEPTH];
    logic [`DMA_TAGW-1:0] tag_mem  [`DMA_QDEPTH];

    // Extra wrap bit tells a full queue from an empty one
    logic [PW:0]   wr_ptr;
    logic [PW:0]   aw_ptr;
    logic [PW:0]   w_ptr;
    // Completion side never compared, index bits only
    logic [PW-1:0] cmp_ptr;

    // Requester holds a credit, so the slot is always free here
    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            addr_mem[wr_ptr[PW-1:0]] <= i_req_addr;
            len_mem[wr_ptr[PW-1:0]]  <= i_req_len;
            op_mem[wr_ptr[PW-1:0]]   <= i_req_op;
            tag_mem[wr_ptr[PW-1:0]]  <= i_req_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            aw_ptr       <= '0;
            w_ptr        <= '0;
            cmp_ptr      <= '0;
            o_req_credit <= 1'b0;
        end
        else begin
            if (i_req_valid) wr_ptr <= wr_ptr + 1'b1;
            if (i_aw_pop)    aw_ptr <= aw_ptr + 1'b1;
            if (i_w_pop)     w_ptr  <= w_ptr + 1'b1;
            if (i_cmp_pop)   cmp_ptr <= cmp_ptr + 1'b1;
            // Freed slot goes back one cycle after the B handshake
            o_req_credit <= i_cmp_pop;
        end
    end

    // AW and W readers trail the writer independently
    always_comb o_aw_avail = (aw_ptr != wr_ptr);
    always_comb o_w_avail  = (w_ptr != wr_ptr);

    always_comb begin
        o_aw_addr = addr_mem[aw_ptr[PW-1:0]];
        o_aw_len  = len_mem[aw_ptr[PW-1:0]];
        o_aw_op   = op_mem[aw_ptr[PW-1:0]];
        o_w_len   = len_mem[w_ptr[PW-1:0]];
        o_cmp_tag = tag_mem[cmp_ptr];
        o_cmp_len = len_mem[cmp_ptr];
    end

endmodule

// ==== hw/dma_wr_complete.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module dma_wr_complete import axi_pkg::*, dma_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  logic                                  i_aw_done,
    input  logic                                  i_w_done,

    // B channel
    input  logic                                  i_bvalid,
    input  axi_resp_e                             i_bresp,
    output logic                                  o_bready,

    // Queue completion side
    input  logic [`DMA_TAGW-1:0]                  i_tag,
    input  logic [`DMA_LENW-1:0]                  i_len,
    output logic                                  o_pop,

    // Completion record
    output logic                                  o_done_valid,
    output logic [`DMA_TAGW-1:0]                  o_done_tag,
    output dma_status_e                           o_done_status,
    output logic [`DMA_LENW+$clog2(`DMA_BC):0]    o_done_bytes
);

    // Up to a full queue outstanding on each side
    logic [$clog2(`DMA_QDEPTH):0] aw_cnt;
    logic [$clog2(`DMA_QDEPTH):0] w_cnt;
    logic                         b_hs;
    logic [`DMA_LENW:0]           beats;
    dma_status_e                  status;

    // B only taken once address and data of the head command are both out
    always_comb o_bready = (aw_cnt != '0) && (w_cnt != '0);
    always_comb b_hs     = i_bvalid && o_bready;
    always_comb o_pop    = b_hs;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_cnt       <= '0;
            w_cnt        <= '0;
            o_done_valid <= 1'b0;
        end
        else begin
            aw_cnt       <= aw_cnt + i_aw_done - b_hs;
            w_cnt        <= w_cnt + i_w_done - b_hs;
            o_done_valid <= b_hs;
        end
    end

    always_comb beats = {1'b0, i_len} + 1'b1;

    always_comb begin
        case (i_bresp)
            SLVERR:  status = DONE_SLV_ERR;
            DECERR:  status = DONE_DEC_ERR;
            // OKAY and EXOKAY
            default: status = DONE_OK;
        endcase
    end

    // Record captured at the handshake, valid the cycle after
    always_ff @(posedge clk) begin
        if (b_hs) begin
            o_done_tag    <= i_tag;
            o_done_status <= status;
            o_done_bytes  <= {beats, {$clog2(`DMA_BC){1'b0}}};
        end
    end

endmodule

// ==== hw/dma_wr_mgr.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module dma_wr_mgr import axi_pkg::*, dma_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,

    // Request port, credit flow control
    input  logic                               i_req_valid,
    input  logic [`DMA_AW-1:0]                 i_req_addr,
    input  logic [`DMA_LENW-1:0]               i_req_len,
    input  dma_op_e                            i_req_op,
    input  logic [`DMA_TAGW-1:0]               i_req_tag,
    output logic                               o_req_credit,

    // Data FIFO
    input  logic                               i_data_valid,
    input  logic [`DMA_DW-1:0]                 i_data,
    output logic                               o_data_ready,

    // AW channel
    output logic                               o_awvalid,
    input  logic                               i_awready,
    output logic [`DMA_AW-1:0]                 o_awaddr,
    output logic [`DMA_LENW-1:0]               o_awlen,
    output logic [2:0]                         o_awsize,
    output axi_burst_e                         o_awburst,
    output logic                               o_awlock,
    output logic                               o_awid,

    // W channel
    output logic                               o_wvalid,
    input  logic                               i_wready,
    output logic [`DMA_DW-1:0]                 o_wdata,
    output logic [`DMA_BC-1:0]                 o_wstrb,
    output logic                               o_wlast,

    // B channel
    input  logic                               i_bvalid,
    input  axi_resp_e                          i_bresp,
    output logic                               o_bready,

    // Completions, in command order
    output logic                               o_done_valid,
    output logic [`DMA_TAGW-1:0]               o_done_tag,
    output dma_status_e                        o_done_status,
    output logic [`DMA_LENW+$clog2(`DMA_BC):0] o_done_bytes
);

    // Queue to address issuer
    logic                 aw_avail;
    logic [`DMA_AW-1:0]   aw_addr;
    logic [`DMA_LENW-1:0] aw_len;
    dma_op_e              aw_op;
    logic                 aw_pop;
    // Queue to data streamer
    logic                 w_avail;
    logic [`DMA_LENW-1:0] w_len;
    logic                 w_pop;
    // Queue to completion unit
    logic                 cmp_pop;
    logic [`DMA_TAGW-1:0] cmp_tag;
    logic [`DMA_LENW-1:0] cmp_len;
    // Channel events for B matching
    logic                 aw_done;
    logic                 w_done;

    dma_req_queue u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .i_req_len    (i_req_len),
        .i_req_op     (i_req_op),
        .i_req_tag    (i_req_tag),
        .o_req_credit (o_req_credit),
        .i_aw_pop     (aw_pop),
        .o_aw_avail   (aw_avail),
        .o_aw_addr    (aw_addr),
        .o_aw_len     (aw_len),
        .o_aw_op      (aw_op),
        .i_w_pop      (w_pop),
        .o_w_avail    (w_avail),
        .o_w_len      (w_len),
        .i_cmp_pop    (cmp_pop),
        .o_cmp_tag    (cmp_tag),
        .o_cmp_len    (cmp_len)
    );

    axi_aw_issue u_aw (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_avail   (aw_avail),
        .i_addr    (aw_addr),
        .i_len     (aw_len),
        .i_op      (aw_op),
        .o_pop     (aw_pop),
        .o_awvalid (o_awvalid),
        .i_awready (i_awready),
        .o_awaddr  (o_awaddr),
        .o_awlen   (o_awlen),
        .o_awsize  (o_awsize),
        .o_awburst (o_awburst),
        .o_awlock  (o_awlock),
        .o_awid    (o_awid),
        .o_aw_done (aw_done)
    );

    axi_w_stream u_w (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_avail      (w_avail),
        .i_len        (w_len),
        .o_pop        (w_pop),
        .i_data_valid (i_data_valid),
        .i_data       (i_data),
        .o_data_ready (o_data_ready),
        .o_wvalid     (o_wvalid),
        .i_wready     (i_wready),
        .o_wdata      (o_wdata),
        .o_wstrb      (o_wstrb),
        .o_wlast      (o_wlast),
        .o_w_done     (w_done)
    );

    dma_wr_complete u_cmp (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_aw_done     (aw_done),
        .i_w_done      (w_done),
        .i_bvalid      (i_bvalid),
        .i_bresp       (i_bresp),
        .o_bready      (o_bready),
        .i_tag         (cmp_tag),
        .i_len         (cmp_len),
        .o_pop         (cmp_pop),
        .o_done_valid  (o_done_valid),
        .o_done_tag    (o_done_tag),
        .o_done_status (o_done_status),
        .o_done_bytes  (o_done_bytes)
    );

endmodule

// ==== sim/tb_dma_wr_mgr.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module tb_dma_wr_mgr import axi_pkg::*, dma_pkg::*; ();

    localparam int N  = 8;
    localparam int BW = `DMA_LENW + $clog2(`DMA_BC) + 1;

    logic                 clk;
    logic                 rst_n;
    logic                 i_req_valid;
    logic [`DMA_AW-1:0]   i_req_addr;
    logic [`DMA_LENW-1:0] i_req_len;
    dma_op_e              i_req_op;
    logic [`DMA_TAGW-1:0] i_req_tag;
    logic                 o_req_credit;
    logic                 i_data_valid;
    logic [`DMA_DW-1:0]   i_data;
    logic                 o_data_ready;
    logic                 o_awvalid;
    logic                 i_awready;
    logic [`DMA_AW-1:0]   o_awaddr;
    logic [`DMA_LENW-1:0] o_awlen;
    logic [2:0]           o_awsize;
    axi_burst_e           o_awburst;
    logic                 o_awlock;
    logic                 o_awid;
    logic                 o_wvalid;
    logic                 i_wready;
    logic [`DMA_DW-1:0]   o_wdata;
    logic [`DMA_BC-1:0]   o_wstrb;
    logic                 o_wlast;
    logic                 i_bvalid;
    axi_resp_e            i_bresp;
    logic                 o_bready;
    logic                 o_done_valid;
    logic [`DMA_TAGW-1:0] o_done_tag;
    dma_status_e          o_done_status;
    logic [BW-1:0]        o_done_bytes;

    // One row per command with its expected results
    logic [`DMA_AW-1:0]   t_addr [N] = '{32'h0000_1000, 32'h0000_2040, 32'h0001_0100,
                                         32'h0002_0000, 32'h8000_0f00, 32'h0000_3ff0,
                                         32'hfeed_0200, 32'h0004_0080};
    logic [`DMA_LENW-1:0] t_len  [N] = '{8'd7, 8'd0, 8'd3, 8'd15, 8'd1, 8'd2, 8'd5, 8'd0};
    dma_op_e              t_op   [N] = '{WR_INCR, WR_FIXED, WR_INCR_LOCK, WR_INCR,
                                         WR_FIXED, WR_INCR, WR_INCR_LOCK, WR_INCR};
    logic [`DMA_TAGW-1:0] t_tag  [N] = '{4'h3, 4'ha, 4'h5, 4'hc, 4'h1, 4'h7, 4'he, 4'h9};
    axi_resp_e            t_bresp [N] = '{OKAY, OKAY, EXOKAY, SLVERR,
                                          DECERR, OKAY, SLVERR, OKAY};
    dma_status_e          t_status [N] = '{DONE_OK, DONE_OK, DONE_OK, DONE_SLV_ERR,
                                           DONE_DEC_ERR, DONE_OK, DONE_SLV_ERR, DONE_OK};
    logic [31:0]          t_bytes [N] = '{32, 4, 16, 64, 8, 12, 24, 4};

    logic [31:0] lfsr = 32'h2531aaad;
    int          err_count = 0;
    int          row_err [N] = '{default: 0};
    // Requester side
    int          post_idx = 0;
    int          credits = `DMA_QDEPTH;
    int          credit_pulses = 0;
    // Expected stream positions
    int          aw_idx = 0;
    int          w_cmd = 0;
    int          w_beat = 0;
    int          b_idx = 0;
    int          done_idx = 0;
    // FIFO model position
    int          fifo_cmd = 0;
    int          fifo_beat = 0;
    logic        fifo_pop = 1'b0;
    logic        b_taken = 1'b0;
    logic        overlap_seen = 1'b0;

    dma_wr_mgr dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_req_valid   (i_req_valid),
        .i_req_addr    (i_req_addr),
        .i_req_len     (i_req_len),
        .i_req_op      (i_req_op),
        .i_req_tag     (i_req_tag),
        .o_req_credit  (o_req_credit),
        .i_data_valid  (i_data_valid),
        .i_data        (i_data),
        .o_data_ready  (o_data_ready),
        .o_awvalid     (o_awvalid),
        .i_awready     (i_awready),
        .o_awaddr      (o_awaddr),
        .o_awlen       (o_awlen),
        .o_awsize      (o_awsize),
        .o_awburst     (o_awburst),
        .o_awlock      (o_awlock),
        .o_awid        (o_awid),
        .o_wvalid      (o_wvalid),
        .i_wready      (i_wready),
        .o_wdata       (o_wdata),
        .o_wstrb       (o_wstrb),
        .o_wlast       (o_wlast),
        .i_bvalid      (i_bvalid),
        .i_bresp       (i_bresp),
        .o_bready      (o_bready),
        .o_done_valid  (o_done_valid),
        .o_done_tag    (o_done_tag),
        .o_done_status (o_done_status),
        .o_done_bytes  (o_done_bytes)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    // Tag in the top byte and beat index below
    function automatic logic [31:0] fifo_word(input int cmd, input int beat);
        return {8'(t_tag[cmd]), 24'(beat)};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp, input int row);
        $display("CHECK FAILED %s row %0d: got 0x%h expected 0x%h", name, row, got, exp);
        err_count = err_count + 1;
        if (row >= 0 && row < N) row_err[row] = row_err[row] + 1;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Checks sample on the rising edge where inputs are stable
    always @(posedge clk) begin : monitor
        axi_burst_e exp_burst;
        logic       exp_last;
        logic       exp_bready;
        if (rst_n) begin
            // B accepted only with an address and a finished burst both outstanding
            exp_bready = (aw_idx > b_idx) && (w_cmd > b_idx);
            if (o_bready !== exp_bready)
                report_mismatch("o_bready", o_bready, exp_bready, b_idx);
            if (o_req_credit) begin
                credits = credits + 1;
                credit_pulses = credit_pulses + 1;
                if (credits > `DMA_QDEPTH) begin
                    $display("More credits returned than commands were posted");
                    err_count = err_count + 1;
                end
            end
            // Credit goes back together with its completion
            if (o_req_credit !== o_done_valid)
                report_mismatch("o_req_credit", o_req_credit, o_done_valid, -1);
            if ((i_data_valid && o_data_ready) !== (o_wvalid && i_wready)) begin
                $display("FIFO word taken without a matching W transfer or the reverse");
                err_count = err_count + 1;
            end
            if (i_data_valid && o_data_ready) begin
                fifo_pop = 1'b1;
                if (fifo_beat == t_len[fifo_cmd]) begin
                    fifo_cmd  = fifo_cmd + 1;
                    fifo_beat = 0;
                end
                else begin
                    fifo_beat = fifo_beat + 1;
                end
            end
            // W beats handled before AW so a same-cycle wlast does not count as overlap
            if (o_wvalid && i_wready) begin
                if (w_cmd >= N) begin
                    $display("W beat transferred after the last burst had ended");
                    err_count = err_count + 1;
                end
                else begin
                    exp_last = (w_beat == t_len[w_cmd]);
                    if (o_wdata !== fifo_word(w_cmd, w_beat))
                        report_mismatch("o_wdata", o_wdata, fifo_word(w_cmd, w_beat), w_cmd);
                    if (o_wstrb !== {`DMA_BC{1'b1}})
                        report_mismatch("o_wstrb", o_wstrb, {`DMA_BC{1'b1}}, w_cmd);
                    if (o_wlast !== exp_last)
                        report_mismatch("o_wlast", o_wlast, exp_last, w_cmd);
                    if (exp_last) begin
                        w_cmd  = w_cmd + 1;
                        w_beat = 0;
                    end
                    else begin
                        w_beat = w_beat + 1;
                    end
                end
            end
            if (o_awvalid && i_awready) begin
                if (aw_idx >= N) begin
                    $display("Address issued after every command already had one");
                    err_count = err_count + 1;
                end
                else begin
                    if (t_op[aw_idx] == WR_FIXED) exp_burst = FIXED;
                    else exp_burst = INCR;
                    if (o_awaddr !== t_addr[aw_idx])
                        report_mismatch("o_awaddr", o_awaddr, t_addr[aw_idx], aw_idx);
                    if (o_awlen !== t_len[aw_idx])
                        report_mismatch("o_awlen", o_awlen, t_len[aw_idx], aw_idx);
                    if (o_awburst !== exp_burst)
                        report_mismatch("o_awburst", o_awburst, exp_burst, aw_idx);
                    if (o_awlock !== (t_op[aw_idx] == WR_INCR_LOCK))
                        report_mismatch("o_awlock", o_awlock,
                                        t_op[aw_idx] == WR_INCR_LOCK, aw_idx);
                    if (o_awsize !== 3'd2)
                        report_mismatch("o_awsize", o_awsize, 3'd2, aw_idx);
                    if (o_awid !== 1'b0)
                        report_mismatch("o_awid", o_awid, 1'b0, aw_idx);
                    // Previous burst still streaming
                    if (aw_idx > 0 && w_cmd < aw_idx) overlap_seen = 1'b1;
                    aw_idx = aw_idx + 1;
                end
            end
            if (i_bvalid && o_bready) begin
                b_idx   = b_idx + 1;
                b_taken = 1'b1;
            end
            if (o_done_valid) begin
                if (done_idx >= N) begin
                    $display("Completion seen after every command had completed");
                    err_count = err_count + 1;
                end
                else begin
                    if (o_done_tag !== t_tag[done_idx])
                        report_mismatch("o_done_tag", o_done_tag, t_tag[done_idx], done_idx);
                    if (o_done_status !== t_status[done_idx])
                        report_mismatch("o_done_status", o_done_status,
                                        t_status[done_idx], done_idx);
                    if (o_done_bytes !== t_bytes[done_idx])
                        report_mismatch("o_done_bytes", o_done_bytes,
                                        t_bytes[done_idx], done_idx);
                    if (row_err[done_idx] == 0)
                        $display("Row %0d tag 0x%h: pass", done_idx, t_tag[done_idx]);
                    else
                        $display("Row %0d tag 0x%h: %0d errors", done_idx,
                                 t_tag[done_idx], row_err[done_idx]);
                    done_idx = done_idx + 1;
                end
            end
        end
    end

    // Requester, FIFO and subordinate driven on the falling edge
    initial begin : driver
        logic b;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            // Post only while a credit is held
            if (post_idx < N && credits > 0) begin
                i_req_valid = 1'b1;
                i_req_addr  = t_addr[post_idx];
                i_req_len   = t_len[post_idx];
                i_req_op    = t_op[post_idx];
                i_req_tag   = t_tag[post_idx];
                credits     = credits - 1;
                post_idx    = post_idx + 1;
            end
            else begin
                i_req_valid = 1'b0;
            end
            // Random stalls on both ready lines
            rand_bit(b);
            i_awready = b;
            rand_bit(b);
            i_wready = b;
            // FIFO holds an offered word until taken
            if (fifo_cmd >= N) begin
                i_data_valid = 1'b0;
            end
            else if (!i_data_valid || fifo_pop) begin
                rand_bit(b);
                i_data_valid = b;
            end
            fifo_pop = 1'b0;
            i_data   = (fifo_cmd < N) ? fifo_word(fifo_cmd, fifo_beat) : '0;
            // B in order once both AW and last W of that command are done
            if (b_taken) begin
                i_bvalid = 1'b0;
                b_taken  = 1'b0;
            end
            if (!i_bvalid && b_idx < aw_idx && b_idx < w_cmd) begin
                i_bvalid = 1'b1;
                i_bresp  = t_bresp[b_idx];
            end
        end
    end

    initial begin : watchdog
        int limit;
        int k;
        limit = 0;
        for (k = 0; k < N; k++) limit = limit + t_len[k] + 2;
        limit = limit * 40;
        @(posedge rst_n);
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d of %0d commands completed",
                 limit, done_idx, N);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        i_req_valid  = 1'b0;
        i_req_addr   = '0;
        i_req_len    = '0;
        i_req_op     = WR_INCR;
        i_req_tag    = '0;
        i_data_valid = 1'b0;
        i_data       = '0;
        i_awready    = 1'b0;
        i_wready     = 1'b0;
        i_bvalid     = 1'b0;
        i_bresp      = OKAY;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        wait (done_idx == N);
        // Idle tail catches stray transfers and late credits
        repeat (10) @(negedge clk);
        if (aw_idx != N) report_mismatch("AW count", aw_idx, N, -1);
        if (w_cmd != N) report_mismatch("burst count", w_cmd, N, -1);
        if (b_idx != N) report_mismatch("B count", b_idx, N, -1);
        if (credit_pulses != done_idx)
            report_mismatch("o_req_credit pulses", credit_pulses, done_idx, -1);
        if (credits != `DMA_QDEPTH) report_mismatch("credits held", credits, `DMA_QDEPTH, -1);
        if (!overlap_seen) begin
            $display("No address was issued while an earlier burst was still streaming");
            err_count = err_count + 1;
        end
        $display("Commands %0d, completions %0d, credits returned %0d, errors %0d",
                 N, done_idx, credit_pulses, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end
        else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
